//--- project.f
design/ctrl_pkg.sv
design/ctrl_decode.sv
design/branch_eval.sv
design/ctrl_pipeline.sv
design/mips_controller.sv
dv/tb_clock.sv
dv/controller_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= controller_tb
RTL_TOP   ?= mips_controller
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Status comes from grep, so a missing pass line fails the target
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/controller_patterns.txt
# instr   cmp_d  ctrl_d   mnemonic
# cmp_d is {equal, g0, e0}; ctrl_d is the 30-bit decode word with pcsrc in bit 0
00221820 0 22800040 add
00221821 0 22800000 addu
00221822 0 22800240 sub
0022182b 0 22800600 sltu
00221827 0 22800a00 nor
00221825 0 22800c00 or
00021900 0 06800080 sll
00021903 0 06800100 sra
00221806 0 16800180 srlv
20220005 0 02000060 addi
24220005 0 02000020 addiu
28220005 0 02000420 slti
30220005 0 02000800 andi
38220005 0 02000e00 xori
3c021234 0 0e000000 lui
80220004 0 02002026 lb
94220004 0 0200202a lhu
8c220004 0 02002036 lw
a4220004 0 00003028 sh
ac220004 0 00003030 sw
08000100 0 00080000 j
0c000100 0 03288000 jal
03e00008 0 00884000 jr
00a0f809 0 02a8c000 jalr
10220008 4 00100001 beq taken
10220008 3 00100000 beq not taken
14220008 0 00110001 bne taken
18200008 1 00140001 blez taken
1c200008 1 00130000 bgtz not taken
04200008 0 00150001 bltz taken
04210008 0 00120000 bgez not taken
04300008 2 03370000 bltzal not taken
04310008 1 03360001 bgezal taken
fc000000 0 00400000 unknown opcode
0000000c 0 00400000 syscall
0000000d 0 00400000 break
00220018 0 00400000 mult
04220008 0 00400000 regimm rt 2
70221802 0 00400000 special2 mul
40000018 0 00400000 eret

//--- dv/controller_tb.sv
`timescale 1ns/10ps
`default_nettype none

module controller_tb;
    import ctrl_pkg::*;

    localparam int    CLK_PERIOD   = 8;
    localparam int    RESET_CYCLES = 10;
    localparam string PATTERN_FILE = "dv/controller_patterns.txt";

    logic        clk;
    logic        rst;
    instr_t      instr;
    cmp_t        cmp_d;
    cmp_t        cmp_e;
    stage_bits_t stall;
    stage_bits_t flush;
    ctrl_t       ctrl_d;
    ctrl_t       ctrl_e;
    ctrl_t       ctrl_m;
    ctrl_t       ctrl_w;
    logic        e_not_taken;

    logic [31:0] instr_q [$];
    logic [2:0]  cmp_q   [$];
    logic [29:0] exp_q   [$];
    int          n_pat = 0;

    ctrl_t       cur_d;              // Expected word on ctrl_d right now
    ctrl_t       model_e;
    ctrl_t       model_m;
    ctrl_t       model_w;
    logic [15:0] lfsr = 16'd61;

    tb_clock u_clock (
        .clk (clk)
    );

    mips_controller DUT (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .cmp_d       (cmp_d),
        .cmp_e       (cmp_e),
        .stall       (stall),
        .flush       (flush),
        .ctrl_d      (ctrl_d),
        .ctrl_e      (ctrl_e),
        .ctrl_m      (ctrl_m),
        .ctrl_w      (ctrl_w),
        .e_not_taken (e_not_taken)
    );

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // Galois LFSR stepped once per bit
    function automatic logic [2:0] draw_bits(input int n);
        logic [2:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++)
        begin
            bits = {bits[1:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 16'hB400 : 16'h0000);
        end
        return bits;
    endfunction

    function automatic logic branch_taken(input ctrl_t c, input cmp_t f);
        logic cond;
        if (c.branch == BR_BEQ)
            cond = f.equal;
        else if (c.branch == BR_BNE)
            cond = !f.equal;
        else if (c.branch == BR_BGEZ || c.branch == BR_BGEZAL)
            cond = f.g0 || f.e0;
        else if (c.branch == BR_BGTZ)
            cond = f.g0;
        else if (c.branch == BR_BLEZ)
            cond = !f.g0;
        else
            cond = !f.g0 && !f.e0;   // BLTZ, BLTZAL
        return c.isbranch && cond;
    endfunction

    function automatic int clamp_idx(input int i);
        return (i < n_pat) ? i : n_pat - 1;
    endfunction

    // Stage rule at a rising edge applied downstream first
    task automatic step_model();
        if (rst || flush.w)
            model_w = '0;
        else if (!stall.w)
            model_w = model_m;
        if (rst || flush.m)
            model_m = '0;
        else if (!stall.m)
            model_m = model_e;
        if (rst || flush.e)
            model_e = '0;
        else if (!stall.e)
            model_e = cur_d;
    endtask

    task automatic pick_controls(input bit random_ctl);
        logic [2:0] a;
        logic [2:0] b;
        logic [2:0] c;
        cmp_e = draw_bits(3);
        stall = '0;
        flush = '0;
        if (random_ctl)
        begin
            a = draw_bits(3);
            b = draw_bits(3);
            stall = a & b;               // About one in four per stage
            a = draw_bits(3);
            b = draw_bits(3);
            c = draw_bits(3);
            flush = a & b & c;
            if (stall.w)
                stall.m = 1'b1;
            if (stall.m)
                stall.e = 1'b1;
        end
    endtask

    task automatic run_phase(input string phase, input bit random_ctl);
        int idx;
        for (int i = 0; i < n_pat + 3; i++)
        begin
            idx = clamp_idx(i);
            @(posedge clk);
            step_model();
            #1;
            instr = instr_q[idx];
            cmp_d = cmp_q[idx];
            cur_d = exp_q[idx];
            pick_controls(random_ctl);
            @(negedge clk);
            check($sformatf("%s pattern %0d ctrl_d", phase, idx), cur_d, ctrl_d);
            check($sformatf("%s cycle %0d ctrl_e", phase, i), model_e, ctrl_e);
            check($sformatf("%s cycle %0d ctrl_m", phase, i), model_m, ctrl_m);
            check($sformatf("%s cycle %0d ctrl_w", phase, i), model_w, ctrl_w);
            check($sformatf("%s cycle %0d e_not_taken", phase, i),
                  !branch_taken(model_e, cmp_e), e_not_taken);
            if (!random_ctl && i >= 3)
            begin
                check($sformatf("latency e cycle %0d", i), exp_q[clamp_idx(i - 1)], ctrl_e);
                check($sformatf("latency m cycle %0d", i), exp_q[clamp_idx(i - 2)], ctrl_m);
                check($sformatf("latency w cycle %0d", i), exp_q[clamp_idx(i - 3)], ctrl_w);
            end
        end
    endtask

    initial
    begin
        wait (n_pat > 0);
        #((n_pat * 4 + 20) * CLK_PERIOD);
        $display("Simulation ran past its time limit");
        $display("Done: errors found");
        $fatal(1, "watchdog timeout");
    end

    initial
    begin
        int          fd;
        string       line;
        logic [31:0] iw;
        logic [31:0] cf;
        logic [31:0] cw;
        rst     = 1'b1;
        instr   = '0;
        cmp_d   = '0;
        cmp_e   = '0;
        stall   = '0;
        flush   = '0;
        cur_d   = '0;
        model_e = '0;
        model_m = '0;
        model_w = '0;

        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0)
        begin
            $display("Could not open the pattern file %s", PATTERN_FILE);
            $display("Done: errors found");
            $fatal(1, "no stimulus");
        end
        while (!$feof(fd))
        begin
            if ($fgets(line, fd) != 0)
            begin
                // Comment lines fail the scan
                if ($sscanf(line, "%h %h %h", iw, cf, cw) == 3)
                begin
                    instr_q.push_back(iw);
                    cmp_q.push_back(cf[2:0]);
                    exp_q.push_back(cw[29:0]);
                end
            end
        end
        $fclose(fd);
        if (instr_q.size() == 0)
        begin
            $display("The pattern file holds no patterns");
            $display("Done: errors found");
            $fatal(1, "no stimulus");
        end
        n_pat = instr_q.size();

        instr = instr_q[0];
        cmp_d = cmp_q[0];
        cur_d = exp_q[0];
        repeat (RESET_CYCLES)
        begin
            @(posedge clk);
            step_model();
        end
        #1;
        rst = 1'b0;
        @(negedge clk);
        check("reset ctrl_e", '0, ctrl_e);
        check("reset ctrl_m", '0, ctrl_m);
        check("reset ctrl_w", '0, ctrl_w);
        check("reset e_not_taken", 1, e_not_taken);

        run_phase("stream", 1'b0);
        run_phase("stall", 1'b1);

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk
);
    localparam int HALF_PERIOD = 4; // 8 ns period

    initial
        clk = 1'b0;

    always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

//--- design/mips_controller.sv
`timescale 1ns/10ps
`default_nettype none

module mips_controller (
    input  logic                  clk,
    input  logic                  rst,
    input  ctrl_pkg::instr_t      instr,
    input  ctrl_pkg::cmp_t        cmp_d,
    input  ctrl_pkg::cmp_t        cmp_e,
    input  ctrl_pkg::stage_bits_t stall,
    input  ctrl_pkg::stage_bits_t flush,
    output ctrl_pkg::ctrl_t       ctrl_d,
    output ctrl_pkg::ctrl_t       ctrl_e,
    output ctrl_pkg::ctrl_t       ctrl_m,
    output ctrl_pkg::ctrl_t       ctrl_w,
    output logic                  e_not_taken
);
    import ctrl_pkg::*;

    ctrl_t dec_word;   // Decoder output with pcsrc still zero
    logic  pcsrc_d;
    logic  taken_e;

    ctrl_decode u_decode (
        .instr (instr),
        .ctrl  (dec_word)
    );

    branch_eval u_branch_d (
        .ctrl  (dec_word),
        .cmp   (cmp_d),
        .taken (pcsrc_d)
    );

    always_comb
    begin
        ctrl_d       = dec_word;
        ctrl_d.pcsrc = pcsrc_d;
    end

    ctrl_pipeline u_pipe (
        .clk    (clk),
        .rst    (rst),
        .ctrl_d (ctrl_d),
        .stall  (stall),
        .flush  (flush),
        .ctrl_e (ctrl_e),
        .ctrl_m (ctrl_m),
        .ctrl_w (ctrl_w)
    );

    // Late resolution against execute-stage operands
    branch_eval u_branch_e (
        .ctrl  (ctrl_e),
        .cmp   (cmp_e),
        .taken (taken_e)
    );

    assign e_not_taken = ~taken_e;

endmodule

`default_nettype wire

//--- design/ctrl_pipeline.sv
`timescale 1ns/10ps
`default_nettype none

module ctrl_pipeline (
    input  logic                  clk,
    input  logic                  rst,
    input  ctrl_pkg::ctrl_t       ctrl_d,
    input  ctrl_pkg::stage_bits_t stall,
    input  ctrl_pkg::stage_bits_t flush,
    output ctrl_pkg::ctrl_t       ctrl_e,
    output ctrl_pkg::ctrl_t       ctrl_m,
    output ctrl_pkg::ctrl_t       ctrl_w
);
    import ctrl_pkg::*;

    ctrl_t                 stage_q  [NUM_STAGES];
    ctrl_t                 stage_in [NUM_STAGES];
    logic [NUM_STAGES-1:0] stall_v;
    logic [NUM_STAGES-1:0] flush_v;

    // Index 0 is execute
    assign stall_v = {stall.w, stall.m, stall.e};
    assign flush_v = {flush.w, flush.m, flush.e};

    assign stage_in[0] = ctrl_d;
    assign stage_in[1] = stage_q[0];
    assign stage_in[2] = stage_q[1];

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < NUM_STAGES; i++)
        begin
            if (rst || flush_v[i])
                stage_q[i] <= '0;            // Flush beats stall
            else if (!stall_v[i])
                stage_q[i] <= stage_in[i];
        end
    end

    assign ctrl_e = stage_q[0];
    assign ctrl_m = stage_q[1];
    assign ctrl_w = stage_q[2];

    // A stalled stage must hold back everything upstream of it
    a_stall_order: assert property (@(posedge clk) disable iff (rst)
        (!stall.m || stall.e) && (!stall.w || stall.m));

    for (genvar g = 0; g < NUM_STAGES; g++)
    begin : g_flush_chk
        a_flush_clears: assert property (@(posedge clk)
            flush_v[g] |=> (stage_q[g] == '0));
    end

endmodule

`default_nettype wire

//--- design/branch_eval.sv
`timescale 1ns/10ps
`default_nettype none

module branch_eval (
    input  ctrl_pkg::ctrl_t ctrl,
    input  ctrl_pkg::cmp_t  cmp,
    output logic            taken
);
    import ctrl_pkg::*;

    logic cond;

    always_comb
    begin
        case (ctrl.branch)
            BR_BEQ:
                cond = cmp.equal;
            BR_BNE:
                cond = !cmp.equal;
            BR_BGEZ, BR_BGEZAL:
                cond = cmp.g0 | cmp.e0;
            BR_BGTZ:
                cond = cmp.g0;
            BR_BLEZ:
                cond = !cmp.g0;
            default:
                cond = !(cmp.g0 | cmp.e0); // BLTZ, BLTZAL
        endcase
    end

    // Only a branch word can redirect
    assign taken = ctrl.isbranch & cond;

endmodule

`default_nettype wire

//--- design/ctrl_decode.sv
`timescale 1ns/10ps
`default_nettype none

module ctrl_decode (
    input  ctrl_pkg::instr_t instr,
    output ctrl_pkg::ctrl_t  ctrl
);
    import ctrl_pkg::*;

    function automatic alu_func_e alu_decode(input instr_t iw);
        if (iw.op == OP_SPECIAL)
        begin
            case (iw.funct)
                FN_SUB, FN_SUBU: return ALU_SUB;
                FN_SLT:          return ALU_SLT;
                FN_SLTU:         return ALU_SLTU;
                FN_AND:          return ALU_AND;
                FN_NOR:          return ALU_NOR;
                FN_OR:           return ALU_OR;
                FN_XOR:          return ALU_XOR;
                default:         return ALU_ADD;
            endcase
        end
        case (iw.op)
            OP_SLTI:  return ALU_SLT;
            OP_SLTIU: return ALU_SLTU;
            OP_ANDI:  return ALU_AND;
            OP_ORI:   return ALU_OR;
            OP_XORI:  return ALU_XOR;
            default:  return ALU_ADD; // Address adds too
        endcase
    endfunction

    function automatic mem_size_e mem_size(input logic [5:0] op);
        case (op[1:0])
            2'b00:   return SZ_BYTE;
            2'b01:   return SZ_HALF;
            default: return SZ_WORD;
        endcase
    endfunction

    always_comb
    begin
        ctrl = '0;
        ctrl.alu_func = alu_decode(instr);
        case (instr.op)
            OP_SPECIAL:
            begin
                ctrl.regwrite = 1'b1;
                ctrl.regdst   = DST_RD;
                case (instr.funct)
                    FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU,
                    FN_AND, FN_OR, FN_XOR, FN_NOR:
                    begin
                        ctrl.alu_srcb_sel_rt = 1'b1;
                        ctrl.intovf_en = (instr.funct == FN_ADD) || (instr.funct == FN_SUB);
                    end
                    // Variable shifts have funct[2] set
                    FN_SLL, FN_SLLV:
                    begin
                        ctrl.out_sel         = OUT_SHIFT;
                        ctrl.sft_func        = SFT_SLL;
                        ctrl.sft_srcb_sel_rs = instr.funct[2];
                    end
                    FN_SRL, FN_SRLV:
                    begin
                        ctrl.out_sel         = OUT_SHIFT;
                        ctrl.sft_func        = SFT_SRL;
                        ctrl.sft_srcb_sel_rs = instr.funct[2];
                    end
                    FN_SRA, FN_SRAV:
                    begin
                        ctrl.out_sel         = OUT_SHIFT;
                        ctrl.sft_func        = SFT_SRA;
                        ctrl.sft_srcb_sel_rs = instr.funct[2];
                    end
                    FN_JR:
                    begin
                        ctrl.regwrite = 1'b0;
                        ctrl.isjump   = 1'b1;
                        ctrl.jump     = JMP_JR;
                    end
                    FN_JALR:
                    begin
                        ctrl.isjump = 1'b1;
                        ctrl.jump   = JMP_JALR;
                        ctrl.link   = 1'b1;
                    end
                    default:
                    begin
                        ctrl.regwrite       = 1'b0;
                        ctrl.regdst         = DST_RT;
                        ctrl.reserved_instr = 1'b1;
                    end
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU:
            begin
                ctrl.regwrite  = 1'b1;
                ctrl.imm_sign  = 1'b1;
                ctrl.intovf_en = (instr.op == OP_ADDI);
            end
            OP_ANDI, OP_ORI, OP_XORI:
                ctrl.regwrite = 1'b1; // Zero-extended immediate
            OP_LUI:
            begin
                ctrl.regwrite         = 1'b1;
                ctrl.out_sel          = OUT_SHIFT;
                ctrl.sft_func         = SFT_LUI;
                ctrl.sft_srca_sel_imm = 1'b1;
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU:
            begin
                ctrl.regwrite   = 1'b1;
                ctrl.memreq     = 1'b1;
                ctrl.memtoreg   = 1'b1;
                ctrl.imm_sign   = 1'b1;
                ctrl.rdata_sign = !instr.op[2]; // LBU, LHU have op[2] set
                ctrl.size       = mem_size(instr.op);
            end
            OP_SB, OP_SH, OP_SW:
            begin
                ctrl.memreq   = 1'b1;
                ctrl.memwr    = 1'b1;
                ctrl.imm_sign = 1'b1;
                ctrl.size     = mem_size(instr.op);
            end
            OP_BEQ:
            begin
                ctrl.isbranch = 1'b1;
                ctrl.branch   = BR_BEQ;
            end
            OP_BNE:
            begin
                ctrl.isbranch = 1'b1;
                ctrl.branch   = BR_BNE;
            end
            OP_BLEZ:
            begin
                ctrl.isbranch = 1'b1;
                ctrl.branch   = BR_BLEZ;
            end
            OP_BGTZ:
            begin
                ctrl.isbranch = 1'b1;
                ctrl.branch   = BR_BGTZ;
            end
            OP_REGIMM:
            begin
                case (instr.rt)
                    RT_BLTZ, RT_BGEZ:
                    begin
                        ctrl.isbranch = 1'b1;
                        ctrl.branch   = instr.rt[0] ? BR_BGEZ : BR_BLTZ;
                    end
                    RT_BLTZAL, RT_BGEZAL:
                    begin
                        ctrl.isbranch = 1'b1;
                        ctrl.branch   = instr.rt[0] ? BR_BGEZAL : BR_BLTZAL;
                        ctrl.link     = 1'b1;
                        ctrl.regwrite = 1'b1;
                        ctrl.regdst   = DST_RA;
                    end
                    default:
                        ctrl.reserved_instr = 1'b1;
                endcase
            end
            OP_J:
            begin
                ctrl.isjump = 1'b1;
                ctrl.jump   = JMP_J;
            end
            OP_JAL:
            begin
                ctrl.isjump   = 1'b1;
                ctrl.jump     = JMP_JAL;
                ctrl.link     = 1'b1;
                ctrl.regwrite = 1'b1;
                ctrl.regdst   = DST_RA; // Return address to r31
            end
            default:
                ctrl.reserved_instr = 1'b1;
        endcase
    end

    always_comb
    begin
        a_store_is_access: assert (!ctrl.memwr || ctrl.memreq)
            else $error("store decoded without a memory request");
    end

endmodule

`default_nettype wire

//--- design/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    // Primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_REGIMM  = 6'b000001;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_BLEZ    = 6'b000110;
    localparam logic [5:0] OP_BGTZ    = 6'b000111;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LB      = 6'b100000;
    localparam logic [5:0] OP_LH      = 6'b100001;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_LBU     = 6'b100100;
    localparam logic [5:0] OP_LHU     = 6'b100101;
    localparam logic [5:0] OP_SB      = 6'b101000;
    localparam logic [5:0] OP_SH      = 6'b101001;
    localparam logic [5:0] OP_SW      = 6'b101011;

    // SPECIAL function codes
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_JALR = 6'b001001;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    // REGIMM branch codes in the rt field
    localparam logic [4:0] RT_BLTZ   = 5'b00000;
    localparam logic [4:0] RT_BGEZ   = 5'b00001;
    localparam logic [4:0] RT_BLTZAL = 5'b10000;
    localparam logic [4:0] RT_BGEZAL = 5'b10001;

    localparam int NUM_STAGES = 3; // Execute, memory, writeback

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_t;

    typedef struct packed {
        logic equal;
        logic g0;
        logic e0;
    } cmp_t;

    typedef struct packed {
        logic e;
        logic m;
        logic w;
    } stage_bits_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR, ALU_OR, ALU_XOR
    } alu_func_e;

    typedef enum logic [1:0] {SFT_LUI, SFT_SLL, SFT_SRA, SFT_SRL} sft_func_e;

    typedef enum logic [2:0] {
        BR_BEQ, BR_BNE, BR_BGEZ, BR_BGTZ, BR_BLEZ, BR_BLTZ, BR_BGEZAL, BR_BLTZAL
    } branch_e;

    typedef enum logic [1:0] {JMP_J, JMP_JR, JMP_JAL, JMP_JALR} jump_e;
    typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA} regdst_e;
    typedef enum logic {OUT_ALU, OUT_SHIFT} out_sel_e;
    typedef enum logic [1:0] {SZ_BYTE, SZ_HALF, SZ_WORD} mem_size_e;

    typedef struct packed {
        logic      alu_srcb_sel_rt;
        logic      sft_srcb_sel_rs;
        logic      sft_srca_sel_imm;
        out_sel_e  out_sel;
        logic      regwrite;
        regdst_e   regdst;
        logic      reserved_instr;
        logic      link;
        logic      isbranch;
        logic      isjump;
        branch_e   branch;
        jump_e     jump;
        logic      memreq;
        logic      memwr;
        alu_func_e alu_func;
        sft_func_e sft_func;
        logic      intovf_en;
        logic      imm_sign;
        mem_size_e size;
        logic      rdata_sign;
        logic      memtoreg;
        logic      pcsrc;        // Decode-stage branch taken
    } ctrl_t;

endpackage

`default_nettype wire
